// ==== Makefile ====
# Verilator build and run of the video transmit path testbench

VERILATOR ?= verilator
TOP       ?= videoTxTb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
common/videoPkg.sv
timing/videoSyncTimer.sv
scene/sceneFadeFsm.sv
scene/sceneBlender.sv
logic/syncAlignDelay.sv
logic/backlightPwm.sv
logic/videoTxUnit.sv
tb/tbClock.sv
tb/videoTxTb.sv

// ==== common/videoPkg.sv ====
/*
 * Shared types and constants of the TFT video transmit path.
 * Imported by the timer, fade control, blender and top level.
 */
package videoPkg;

	// ----------------------------------------------------------
	// Pixel and timing types
	// ----------------------------------------------------------
	// Line and pixel position width
	localparam int cPosWidth = 11;

	// RGB 4:4:4 output pixel
	typedef struct packed {
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} rgbPixel;

	// Timing bundle, syncs active low
	typedef struct packed {
		logic                 hSync;
		logic                 vSync;
		logic                 de;
		logic [cPosWidth-1:0] hPos;
		logic [cPosWidth-1:0] vPos;
	} videoTiming;

	// Blend weight, 0 means bars only, 16 means scene colour only
	typedef logic [4:0] fadeAlpha;

	localparam fadeAlpha cAlphaMax = 5'd16;

	// ----------------------------------------------------------
	// Constants
	// ----------------------------------------------------------
	// Classic eight colour bars, left to right
	localparam rgbPixel barPalette [8] = '{
		'{4'hF, 4'hF, 4'hF},
		'{4'hF, 4'hF, 4'h0},
		'{4'h0, 4'hF, 4'hF},
		'{4'h0, 4'hF, 4'h0},
		'{4'hF, 4'h0, 4'hF},
		'{4'hF, 4'h0, 4'h0},
		'{4'h0, 4'h0, 4'hF},
		'{4'h0, 4'h0, 4'h0}
	};

	// Blanked timing, both syncs released
	localparam videoTiming cIdleTiming = '{hSync: 1'b1, vSync: 1'b1, de: 1'b0,
		hPos: '0, vPos: '0};

endpackage

// ==== logic/backlightPwm.sv ====
/*
 * Eight-bit free-running PWM for panel backlight dimming.
 * Output is high for iBlDutyRatio clocks of every 256.
 */
module backlightPwm (
	input  logic       iVideoClk,
	input  logic       rstN,
	input  logic [7:0] iBlDutyRatio,
	output logic       tftBackLight
);

	logic [7:0] pwmCnt;

	// ----------------------------------------------------------
	// Period counter
	// ----------------------------------------------------------
	// Wraps naturally every 256 clocks
	always_ff @(posedge iVideoClk)
	begin
		if (!rstN)
			pwmCnt <= '0;
		else
			pwmCnt <= pwmCnt + 1'b1;
	end

	// Duty compare, zero duty keeps backlight off
	assign tftBackLight = (pwmCnt < iBlDutyRatio);

endmodule

// ==== logic/syncAlignDelay.sv ====
/*
 * Register chain that delays a payload by a fixed number of clocks.
 * Keeps the timing bundle in step with the pixel pipeline.
 */
module syncAlignDelay #(
	parameter type     tPayload = logic,
	parameter int      pLatency = 1,
	parameter tPayload pIdle    = tPayload'(0)
)(
	input  logic    iVideoClk,
	input  logic    rstN,
	input  tPayload din,
	output tPayload dout
);

	tPayload stage [pLatency];

	always_ff @(posedge iVideoClk)
	begin
		if (!rstN)
		begin
			// Idle payload in every stage
			for (int i = 0; i < pLatency; i++)
				stage[i] <= pIdle;
		end
		else
		begin
			stage[0] <= din;
			for (int i = 1; i < pLatency; i++)
				stage[i] <= stage[i-1];
		end
	end

	assign dout = stage[pLatency-1];

endmodule

// ==== logic/videoTxUnit.sv ====
/*
 * Top of the TFT video transmit path, all in the video clock domain.
 * Joins sync timer, scene fade, blender, alignment delay and backlight PWM.
 */
module videoTxUnit #(
	parameter int pHActive    = 480,
	parameter int pHSyncStart = 482,
	parameter int pHSyncEnd   = 523,
	parameter int pHTotal     = 525,
	parameter int pVActive    = 272,
	parameter int pVSyncStart = 274,
	parameter int pVSyncEnd   = 284,
	parameter int pVTotal     = 286,
	parameter int pBarShift   = 6
)(
	input  logic              iVideoClk,
	input  logic              rstN,
	input  videoPkg::rgbPixel iSceneColor,
	input  logic [6:0]        iSceneFrameTiming,
	input  logic              iSceneFrameAddEn,
	input  logic              iSceneFrameSubEn,
	input  logic              iSceneFrameRst,
	input  logic [7:0]        iBlDutyRatio,
	output videoPkg::rgbPixel tftColor,
	output logic              tftHSync,
	output logic              tftVSync,
	output logic              tftDe,
	output logic              tftBackLight,
	output logic              sceneAlphaMax,
	output logic              sceneAlphaMin,
	output logic              frameEnd
);

	import videoPkg::*;

	// Blender pipeline depth, sync path matches it
	localparam int lpAlignLatency = 1;

	videoTiming rawTiming;
	videoTiming alignTiming;
	fadeAlpha   alpha;

	// ----------------------------------------------------------
	// Timing and fade control
	// ----------------------------------------------------------
	videoSyncTimer #(
		.pHActive    (pHActive),
		.pHSyncStart (pHSyncStart),
		.pHSyncEnd   (pHSyncEnd),
		.pHTotal     (pHTotal),
		.pVActive    (pVActive),
		.pVSyncStart (pVSyncStart),
		.pVSyncEnd   (pVSyncEnd),
		.pVTotal     (pVTotal)
	) syncTimer (
		.iVideoClk (iVideoClk),
		.rstN      (rstN),
		.timing    (rawTiming),
		.frameEnd  (frameEnd)
	);

	sceneFadeFsm fadeFsm (
		.iVideoClk         (iVideoClk),
		.rstN              (rstN),
		.frameEnd          (frameEnd),
		.iSceneFrameTiming (iSceneFrameTiming),
		.iSceneFrameAddEn  (iSceneFrameAddEn),
		.iSceneFrameSubEn  (iSceneFrameSubEn),
		.iSceneFrameRst    (iSceneFrameRst),
		.alpha             (alpha),
		.sceneAlphaMax     (sceneAlphaMax),
		.sceneAlphaMin     (sceneAlphaMin)
	);

	// ----------------------------------------------------------
	// Pixel path and sync alignment
	// ----------------------------------------------------------
	sceneBlender #(
		.pBarShift (pBarShift)
	) blender (
		.iVideoClk   (iVideoClk),
		.rstN        (rstN),
		.timing      (rawTiming),
		.alpha       (alpha),
		.iSceneColor (iSceneColor),
		.pixel       (tftColor)
	);

	syncAlignDelay #(
		.tPayload (videoTiming),
		.pLatency (lpAlignLatency),
		.pIdle    (cIdleTiming)
	) alignDelay (
		.iVideoClk (iVideoClk),
		.rstN      (rstN),
		.din       (rawTiming),
		.dout      (alignTiming)
	);

	// Panel control lines
	assign tftHSync = alignTiming.hSync;
	assign tftVSync = alignTiming.vSync;
	assign tftDe    = alignTiming.de;

	backlightPwm blPwm (
		.iVideoClk    (iVideoClk),
		.rstN         (rstN),
		.iBlDutyRatio (iBlDutyRatio),
		.tftBackLight (tftBackLight)
	);

endmodule

// ==== scene/sceneBlender.sv ====
/*
 * Colour-bar pixel source blended with the scene colour by alpha.
 * One registered stage, output blanked outside the active area.
 */
module sceneBlender #(
	parameter int pBarShift = 6
)(
	input  logic                 iVideoClk,
	input  logic                 rstN,
	input  videoPkg::videoTiming timing,
	input  videoPkg::fadeAlpha   alpha,
	input  videoPkg::rgbPixel    iSceneColor,
	output videoPkg::rgbPixel    pixel
);

	import videoPkg::*;

	logic [2:0] barIdx;
	rgbPixel    basePixel;
	rgbPixel    mixPixel;

	// Weighted sum of one channel, divided by 16
	function automatic logic [3:0] blendChan(input logic [3:0] base,
		input logic [3:0] scene, input fadeAlpha a);
		logic [8:0] mix;
		mix = base * (cAlphaMax - a) + scene * a;
		return mix[7:4];
	endfunction

	// Bar number from position, wraps after eight bars
	assign barIdx    = 3'(timing.hPos >> pBarShift);
	assign basePixel = barPalette[barIdx];

	assign mixPixel.red   = blendChan(basePixel.red,   iSceneColor.red,   alpha);
	assign mixPixel.green = blendChan(basePixel.green, iSceneColor.green, alpha);
	assign mixPixel.blue  = blendChan(basePixel.blue,  iSceneColor.blue,  alpha);

	// ----------------------------------------------------------
	// Output stage
	// ----------------------------------------------------------
	always_ff @(posedge iVideoClk)
	begin
		if (!rstN)
			pixel <= '0;
		// Black during blanking
		else if (timing.de)
			pixel <= mixPixel;
		else
			pixel <= '0;
	end

endmodule

// ==== scene/sceneFadeFsm.sv ====
/*
 * Scene fade control, steps the blend alpha once per set number of frames.
 * Add and sub requests start a fade, the frame reset clears alpha at once.
 */
module sceneFadeFsm (
	input  logic               iVideoClk,
	input  logic               rstN,
	input  logic               frameEnd,
	input  logic [6:0]         iSceneFrameTiming,
	input  logic               iSceneFrameAddEn,
	input  logic               iSceneFrameSubEn,
	input  logic               iSceneFrameRst,
	output videoPkg::fadeAlpha alpha,
	output logic               sceneAlphaMax,
	output logic               sceneAlphaMin
);

	import videoPkg::*;

	typedef enum logic [1:0] {Idle, FadeIn, FadeOut} fadeState;

	fadeState   state;
	logic [6:0] divCnt;
	logic       addDly;
	logic       subDly;
	logic       addReq;
	logic       subReq;
	logic       stepNow;

	// Rising edge of each request, so a held level starts one fade
	assign addReq  = iSceneFrameAddEn && !addDly;
	assign subReq  = iSceneFrameSubEn && !subDly;
	// Frame divider reached its terminal count
	assign stepNow = frameEnd && (divCnt == iSceneFrameTiming);

	always_ff @(posedge iVideoClk)
	begin
		if (!rstN)
		begin
			state  <= Idle;
			alpha  <= '0;
			divCnt <= '0;
			addDly <= 1'b0;
			subDly <= 1'b0;
		end
		else
		begin
			addDly <= iSceneFrameAddEn;
			subDly <= iSceneFrameSubEn;
			if (iSceneFrameRst)
			begin
				state  <= Idle;
				alpha  <= '0;
				divCnt <= '0;
			end
			// Add wins over sub in the same cycle
			else if (addReq)
			begin
				state  <= FadeIn;
				divCnt <= '0;
			end
			else if (subReq)
			begin
				state  <= FadeOut;
				divCnt <= '0;
			end
			else if (state != Idle)
			begin
				// Fade already at its end value
				if ((state == FadeIn) ? (alpha == cAlphaMax) : (alpha == '0))
					state <= Idle;
				else if (stepNow)
				begin
					divCnt <= '0;
					if (state == FadeIn)
					begin
						alpha <= alpha + 1'b1;
						if (alpha == cAlphaMax - 1'b1)
							state <= Idle;
					end
					else
					begin
						alpha <= alpha - 1'b1;
						if (alpha == 5'd1)
							state <= Idle;
					end
				end
				else if (frameEnd)
					divCnt <= divCnt + 1'b1;
			end
		end
	end

	// End-of-fade flags
	assign sceneAlphaMax = (alpha == cAlphaMax);
	assign sceneAlphaMin = (alpha == '0);

	// Alpha stays in range across any request sequence
	assert property (@(posedge iVideoClk) disable iff (!rstN) alpha <= cAlphaMax);
	assert property (@(posedge iVideoClk) disable iff (!rstN)
		!(sceneAlphaMax && sceneAlphaMin));

endmodule

// ==== tb/tbClock.sv ====
/*
 * Testbench clock and reset source.
 * Reset is released on a falling edge after the set number of cycles.
 */
module tbClock #(
	parameter int pPeriod      = 4,
	parameter int pResetCycles = 8
)(
	output logic clk,
	output logic rstN
);

	initial
	begin
		clk = 1'b0;
		forever #(pPeriod / 2) clk = !clk;
	end

	// Held low, then released away from the sampling edge
	initial
	begin
		rstN = 1'b0;
		repeat (pResetCycles) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
	end

endmodule

// ==== tb/videoTxTb.sv ====
/*
 * Testbench of the video transmit path, small panel timing.
 * Trackers and concurrent assertions check outputs; stimulus steps through the tests.
 */
module videoTxTb;

	import videoPkg::*;

	localparam int cClockPeriod = 4;
	localparam int cFrameClocks = 24 * 9;
	// Frames per test: sync, bars, fade in, fade out, frame reset, backlight
	localparam int cTestFrames  = 3 + 2 + 19 + 35 + 8 + 3;
	localparam longint cTimeout = (cTestFrames + 20) * cFrameClocks * cClockPeriod;

	logic       iVideoClk;
	logic       rstN;
	rgbPixel    iSceneColor;
	logic [6:0] iSceneFrameTiming;
	logic       iSceneFrameAddEn;
	logic       iSceneFrameSubEn;
	logic       iSceneFrameRst;
	logic [7:0] iBlDutyRatio;
	rgbPixel    tftColor;
	logic       tftHSync;
	logic       tftVSync;
	logic       tftDe;
	logic       tftBackLight;
	logic       sceneAlphaMax;
	logic       sceneAlphaMin;
	logic       frameEnd;

	integer       seed;
	int           errCount;
	int           testCount;
	int           testFails;
	int           testErrStart;
	// Tracker state, updated on every rising edge
	int           deRun;
	int           deLines;
	int           hsLowRun;
	int           hsPeriod;
	int           vsLowRun;
	int           vsFalls;
	int           frameGap;
	int           frameTotal;
	int           rstAge;
	logic         prevDe;
	logic         prevHs;
	logic         prevVs;
	logic         prevMax;
	logic         prevMin;
	logic [255:0] blHist;
	int           blOnes;
	int           blFill;
	// Expectations set by the stimulus
	logic         pixCheck;
	int           expectAlpha;
	int           fadeStart;
	int           fadeFrames;
	logic         blCheck;

	tbClock #(.pPeriod(cClockPeriod), .pResetCycles(8)) clkGen (
		.clk  (iVideoClk),
		.rstN (rstN)
	);

	videoTxUnit #(
		.pHActive    (16),
		.pHSyncStart (18),
		.pHSyncEnd   (20),
		.pHTotal     (24),
		.pVActive    (6),
		.pVSyncStart (7),
		.pVSyncEnd   (8),
		.pVTotal     (9),
		.pBarShift   (1)
	) dut (
		.iVideoClk         (iVideoClk),
		.rstN              (rstN),
		.iSceneColor       (iSceneColor),
		.iSceneFrameTiming (iSceneFrameTiming),
		.iSceneFrameAddEn  (iSceneFrameAddEn),
		.iSceneFrameSubEn  (iSceneFrameSubEn),
		.iSceneFrameRst    (iSceneFrameRst),
		.iBlDutyRatio      (iBlDutyRatio),
		.tftColor          (tftColor),
		.tftHSync          (tftHSync),
		.tftVSync          (tftVSync),
		.tftDe             (tftDe),
		.tftBackLight      (tftBackLight),
		.sceneAlphaMax     (sceneAlphaMax),
		.sceneAlphaMin     (sceneAlphaMin),
		.frameEnd          (frameEnd)
	);

	// ----------------------------------------------------------
	// Expected values
	// ----------------------------------------------------------
	// White, yellow, cyan, green, magenta, red, blue, black
	function automatic rgbPixel barColour(input int idx);
		case (idx)
			0: return 12'hFFF;
			1: return 12'hFF0;
			2: return 12'h0FF;
			3: return 12'h0F0;
			4: return 12'hF0F;
			5: return 12'hF00;
			6: return 12'h00F;
			default: return 12'h000;
		endcase
	endfunction

	function automatic logic [3:0] mixChan(input int base, input int scene, input int a);
		return 4'((base * (16 - a) + scene * a) / 16);
	endfunction

	// n-th active pixel of a line at blend weight a
	function automatic rgbPixel expectPixel(input int n, input rgbPixel scene, input int a);
		rgbPixel bar;
		rgbPixel res;
		bar       = barColour((n >> 1) % 8);
		res.red   = mixChan(int'(bar.red), int'(scene.red), a);
		res.green = mixChan(int'(bar.green), int'(scene.green), a);
		res.blue  = mixChan(int'(bar.blue), int'(scene.blue), a);
		return res;
	endfunction

	task automatic reportMismatch(input string sigName, input int expVal, input int actVal);
		errCount++;
		$display("mismatch at time %0t: %s expected %0h, actual %0h", $time, sigName,
			expVal, actVal);
	endtask

	// ----------------------------------------------------------
	// Output trackers
	// ----------------------------------------------------------
	always @(posedge iVideoClk)
	begin
		if (!rstN)
		begin
			{deRun, deLines, hsLowRun, hsPeriod, frameGap, frameTotal} <= '0;
			{rstAge, blOnes, blFill, vsLowRun, vsFalls} <= '0;
			blHist  <= '0;
			prevDe  <= 1'b0;
			prevHs  <= 1'b1;
			prevVs  <= 1'b1;
			prevMax <= 1'b0;
			prevMin <= 1'b1;
		end
		else
		begin
			prevDe   <= tftDe;
			prevHs   <= tftHSync;
			prevVs   <= tftVSync;
			prevMax  <= sceneAlphaMax;
			prevMin  <= sceneAlphaMin;
			deRun    <= tftDe ? deRun + 1 : 0;
			hsLowRun <= tftHSync ? 0 : hsLowRun + 1;
			vsLowRun <= tftVSync ? 0 : vsLowRun + 1;
			// Clocks since the last hSync fall
			if (prevHs && !tftHSync)
				hsPeriod <= 1;
			else if (hsPeriod != 0)
				hsPeriod <= hsPeriod + 1;
			if (frameEnd)
			begin
				frameGap   <= 1;
				frameTotal <= frameTotal + 1;
				deLines    <= 0;
				vsFalls    <= 0;
			end
			else
			begin
				if (frameGap != 0)
					frameGap <= frameGap + 1;
				if (prevDe && !tftDe)
					deLines <= deLines + 1;
				// vSync pulses since the last frame end
				if (prevVs && !tftVSync)
					vsFalls <= vsFalls + 1;
			end
			// Age of the last frame reset pulse, stops at 3
			if (iSceneFrameRst)
				rstAge <= 1;
			else if (rstAge != 0 && rstAge < 3)
				rstAge <= rstAge + 1;
			// Sliding 256-clock window of the backlight
			blHist <= {blHist[254:0], tftBackLight};
			blOnes <= blOnes + int'(tftBackLight) - int'(blHist[255]);
			if (blFill < 256)
				blFill <= blFill + 1;
		end
	end

	// ----------------------------------------------------------
	// Checks
	// ----------------------------------------------------------
	chkDeRun: assert property (@(posedge iVideoClk) disable iff (!rstN)
		(prevDe && !tftDe) |-> deRun == 16)
		else reportMismatch("tftDe cycles per line", 16, $sampled(deRun));
	chkDeLines: assert property (@(posedge iVideoClk) disable iff (!rstN)
		frameEnd |-> deLines == 6)
		else reportMismatch("tftDe lines per frame", 6, $sampled(deLines));
	chkHsLow: assert property (@(posedge iVideoClk) disable iff (!rstN)
		(!prevHs && tftHSync) |-> hsLowRun == 2)
		else reportMismatch("tftHSync low clocks", 2, $sampled(hsLowRun));
	chkHsPeriod: assert property (@(posedge iVideoClk) disable iff (!rstN)
		(prevHs && !tftHSync && hsPeriod != 0) |-> hsPeriod == 24)
		else reportMismatch("tftHSync period", 24, $sampled(hsPeriod));
	chkVsLow: assert property (@(posedge iVideoClk) disable iff (!rstN)
		(!prevVs && tftVSync) |-> vsLowRun == 24)
		else reportMismatch("tftVSync low clocks", 24, $sampled(vsLowRun));
	chkVsFalls: assert property (@(posedge iVideoClk) disable iff (!rstN)
		frameEnd |-> vsFalls == 1)
		else reportMismatch("tftVSync pulses per frame", 1, $sampled(vsFalls));
	chkFrameGap: assert property (@(posedge iVideoClk) disable iff (!rstN)
		(frameEnd && frameGap != 0) |-> frameGap == cFrameClocks)
		else reportMismatch("frameEnd period", cFrameClocks, $sampled(frameGap));
	chkBlank: assert property (@(posedge iVideoClk) disable iff (!rstN)
		!tftDe |-> tftColor == '0)
		else reportMismatch("tftColor in blanking", 0, int'($sampled(tftColor)));
	chkPixel: assert property (@(posedge iVideoClk) disable iff (!rstN)
		(pixCheck && tftDe) |-> tftColor == expectPixel(deRun, iSceneColor, expectAlpha))
		else reportMismatch("tftColor", int'(expectPixel($sampled(deRun),
			$sampled(iSceneColor), $sampled(expectAlpha))), int'($sampled(tftColor)));
	chkMinLow: assert property (@(posedge iVideoClk) disable iff (!rstN)
		(pixCheck && expectAlpha == 16) |-> !sceneAlphaMin)
		else reportMismatch("sceneAlphaMin", 0, 1);
	chkMaxFrames: assert property (@(posedge iVideoClk) disable iff (!rstN)
		(sceneAlphaMax && !prevMax && fadeFrames != 0) |-> frameTotal - fadeStart == fadeFrames)
		else reportMismatch("frames to sceneAlphaMax", $sampled(fadeFrames),
			$sampled(frameTotal) - $sampled(fadeStart));
	chkMinFrames: assert property (@(posedge iVideoClk) disable iff (!rstN)
		(sceneAlphaMin && !prevMin && fadeFrames != 0) |-> frameTotal - fadeStart == fadeFrames)
		else reportMismatch("frames to sceneAlphaMin", $sampled(fadeFrames),
			$sampled(frameTotal) - $sampled(fadeStart));
	chkRstMin: assert property (@(posedge iVideoClk) disable iff (!rstN)
		(rstAge == 2) |-> sceneAlphaMin)
		else reportMismatch("sceneAlphaMin after frame reset", 1, 0);
	chkBacklight: assert property (@(posedge iVideoClk) disable iff (!rstN)
		(blCheck && blFill == 256) |-> blOnes == int'(iBlDutyRatio))
		else reportMismatch("tftBackLight high clocks", int'($sampled(iBlDutyRatio)),
			$sampled(blOnes));

	// ----------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------
	task automatic waitFrames(input int n);
		int target;
		target = frameTotal + n;
		while (frameTotal < target)
			@(negedge iVideoClk);
	endtask

	task automatic finishTest(input string name);
		testCount++;
		if (errCount == testErrStart)
			$display("test %0d %s: pass", testCount, name);
		else
		begin
			testFails++;
			$display("test %0d %s: fail, %0d errors", testCount, name, errCount - testErrStart);
		end
		testErrStart = errCount;
	endtask

	// Bars back at alpha 0 for the given frames
	task automatic checkBars(input int frames);
		repeat (2) @(negedge iVideoClk);
		expectAlpha = 0;
		pixCheck    = 1'b1;
		waitFrames(frames);
		pixCheck    = 1'b0;
	endtask

	initial
	begin
		seed              = 32'h6869859b;
		iSceneColor       = rgbPixel'(12'($random(seed)));
		iBlDutyRatio      = 8'($random(seed));
		iSceneFrameTiming = '0;
		iSceneFrameAddEn  = 1'b0;
		iSceneFrameSubEn  = 1'b0;
		iSceneFrameRst    = 1'b0;
		{errCount, testCount, testFails, testErrStart} = '0;
		{expectAlpha, fadeStart, fadeFrames} = '0;
		pixCheck = 1'b0;
		blCheck  = 1'b0;
		@(posedge rstN);
		@(negedge iVideoClk);

		// Sync checks run all the time
		waitFrames(3);
		finishTest("sync timing");
		checkBars(2);
		finishTest("colour bars and blanking");

		// Fade in, one step per frame
		waitFrames(1);
		iSceneFrameTiming = 7'd0;
		fadeFrames        = 16;
		fadeStart         = frameTotal;
		iSceneFrameAddEn  = 1'b1;
		@(negedge iVideoClk);
		iSceneFrameAddEn  = 1'b0;
		while (!sceneAlphaMax)
			@(negedge iVideoClk);
		repeat (2) @(negedge iVideoClk);
		expectAlpha = 16;
		pixCheck    = 1'b1;
		waitFrames(2);
		pixCheck    = 1'b0;
		finishTest("fade in");

		// Fade out, one step per two frames
		waitFrames(1);
		iSceneFrameTiming = 7'd1;
		fadeFrames        = 32;
		fadeStart         = frameTotal;
		iSceneFrameSubEn  = 1'b1;
		@(negedge iVideoClk);
		iSceneFrameSubEn  = 1'b0;
		// Halfway, alpha down by 8
		waitFrames(16);
		expectAlpha = 8;
		pixCheck    = 1'b1;
		waitFrames(1);
		pixCheck    = 1'b0;
		while (!sceneAlphaMin)
			@(negedge iVideoClk);
		checkBars(1);
		finishTest("fade out");

		// Frame reset in the middle of a fade in
		waitFrames(1);
		fadeFrames        = 0;
		iSceneFrameTiming = 7'd0;
		iSceneFrameAddEn  = 1'b1;
		@(negedge iVideoClk);
		iSceneFrameAddEn  = 1'b0;
		waitFrames(5);
		repeat (50) @(negedge iVideoClk);
		iSceneFrameRst = 1'b1;
		@(negedge iVideoClk);
		iSceneFrameRst = 1'b0;
		checkBars(2);
		finishTest("frame reset");

		blCheck = 1'b1;
		repeat (600) @(negedge iVideoClk);
		blCheck = 1'b0;
		finishTest("backlight");

		$display("tests run %0d, failed %0d, mismatches %0d", testCount, testFails, errCount);
		if (errCount == 0 && testFails == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// Watchdog over the summed test lengths
	initial
	begin
		#(cTimeout);
		$display("timeout: the tests did not finish within %0d time units", cTimeout);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== timing/videoSyncTimer.sv ====
/*
 * Horizontal and vertical display timing generator.
 * Gives registered syncs, data enable, position and a frame-end strobe.
 */
module videoSyncTimer #(
	parameter int pHActive    = 480,
	parameter int pHSyncStart = 482,
	parameter int pHSyncEnd   = 523,
	parameter int pHTotal     = 525,
	parameter int pVActive    = 272,
	parameter int pVSyncStart = 274,
	parameter int pVSyncEnd   = 284,
	parameter int pVTotal     = 286
)(
	input  logic                 iVideoClk,
	input  logic                 rstN,
	output videoPkg::videoTiming timing,
	output logic                 frameEnd
);

	import videoPkg::*;

	logic [cPosWidth-1:0] hCnt;
	logic [cPosWidth-1:0] vCnt;
	logic                 lastPixel;
	logic                 lastLine;

	// Wrap points of both counters
	assign lastPixel = (hCnt == cPosWidth'(pHTotal - 1));
	assign lastLine  = (vCnt == cPosWidth'(pVTotal - 1));

	// ----------------------------------------------------------
	// Counters and decoded timing
	// ----------------------------------------------------------
	always_ff @(posedge iVideoClk)
	begin
		if (!rstN)
		begin
			hCnt     <= '0;
			vCnt     <= '0;
			timing   <= cIdleTiming;
			frameEnd <= 1'b0;
		end
		else
		begin
			// Pixel counter, line counter steps at end of line
			if (lastPixel)
			begin
				hCnt <= '0;
				vCnt <= lastLine ? '0 : vCnt + 1'b1;
			end
			else
				hCnt <= hCnt + 1'b1;

			// Decode from current count, lands with its position
			timing.hSync <= !((hCnt >= pHSyncStart) && (hCnt < pHSyncEnd));
			timing.vSync <= !((vCnt >= pVSyncStart) && (vCnt < pVSyncEnd));
			timing.de    <= (hCnt < pHActive) && (vCnt < pVActive);
			timing.hPos  <= hCnt;
			timing.vPos  <= vCnt;
			// Last clock of the last line
			frameEnd     <= lastPixel && lastLine;
		end
	end

	// Counters never run past their totals
	assert property (@(posedge iVideoClk) disable iff (!rstN)
		(hCnt < pHTotal) && (vCnt < pVTotal));

endmodule
